//--- design/rf_axil_slave.sv
/* AXI4-Lite slave in front of the register file port bundle.
   Writes need address and data together and a full strobe, else SLVERR.
   Reads capture port A and hold the data until the master takes it. */

`timescale 1ns/10ps

module rf_axil_slave (
  input  logic                            clk_int,
  input  logic                            rst_n,
  // Write address channel
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [rf_pkg::AXI_ADDR_W-1:0]   awaddr_i,
  // Write data channel
  input  logic                            wvalid_i,
  output logic                            wready_o,
  input  logic [rf_pkg::RF_DATA_W-1:0]    wdata_i,
  input  logic [rf_pkg::AXI_STRB_W-1:0]   wstrb_i,
  // Write response channel
  output logic                            bvalid_o,
  input  logic                            bready_i,
  output logic [rf_pkg::AXI_RESP_W-1:0]   bresp_o,
  // Read address channel
  input  logic                            arvalid_i,
  output logic                            arready_o,
  input  logic [rf_pkg::AXI_ADDR_W-1:0]   araddr_i,
  // Read data channel
  output logic                            rvalid_o,
  input  logic                            rready_i,
  output logic [rf_pkg::RF_DATA_W-1:0]    rdata_o,
  output logic [rf_pkg::AXI_RESP_W-1:0]   rresp_o,
  // Register file access
  rf_port_if.bus                          rf
);
  import rf_pkg::*;

  typedef enum logic {WR_IDLE, WR_RESP} wr_state_e;
  typedef enum logic {RD_IDLE, RD_RESP} rd_state_e;

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q, rd_state_d;

  // Ready flags stay low in reset and rise one cycle after release
  logic wr_ready_q;
  logic rd_ready_q;

  logic wr_accept;
  logic rd_accept;
  logic strb_full;

  logic [AXI_RESP_W-1:0] bresp_q;
  logic [RF_DATA_W-1:0]  rdata_q;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Address and data are taken in the same cycle only
  assign wr_accept = wr_ready_q & awvalid_i & wvalid_i;
  assign awready_o = wr_accept;
  assign wready_o  = wr_accept;

  // Partial writes are refused
  assign strb_full = (wstrb_i == '1);

  // Register file write goes out in the acceptance cycle
  assign rf.we    = wr_accept & strb_full;
  assign rf.waddr = awaddr_i[AXI_ADDR_W-1:AXI_IDX_LSB];
  assign rf.wdata = wdata_i;

  always_comb begin
    wr_state_d = wr_state_q;
    case (wr_state_q)
      WR_IDLE: if (wr_accept) wr_state_d = WR_RESP;
      WR_RESP: if (bready_i) wr_state_d = WR_IDLE;
      default: wr_state_d = WR_IDLE;
    endcase
  end

  always_ff @(posedge clk_int or negedge rst_n) begin
    if (!rst_n) begin
      wr_state_q <= WR_IDLE;
      wr_ready_q <= 1'b0;
      bresp_q    <= AXI_RESP_OKAY;
    end else begin
      wr_state_q <= wr_state_d;
      // Ready again in the cycle after the response is taken
      wr_ready_q <= (wr_state_d == WR_IDLE);
      if (wr_accept) begin
        bresp_q <= strb_full ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
      end
    end
  end

  assign bvalid_o = (wr_state_q == WR_RESP);
  assign bresp_o  = bresp_q;

  ////////////////////////////////////////////////////////////
  // Read side
  ////////////////////////////////////////////////////////////

  assign rd_accept = rd_ready_q & arvalid_i;
  assign arready_o = rd_ready_q;

  // Port A is looked up straight from the bus address
  assign rf.raddr_a = araddr_i[AXI_ADDR_W-1:AXI_IDX_LSB];

  always_comb begin
    rd_state_d = rd_state_q;
    case (rd_state_q)
      RD_IDLE: if (rd_accept) rd_state_d = RD_RESP;
      RD_RESP: if (rready_i) rd_state_d = RD_IDLE;
      default: rd_state_d = RD_IDLE;
    endcase
  end

  always_ff @(posedge clk_int or negedge rst_n) begin
    if (!rst_n) begin
      rd_state_q <= RD_IDLE;
      rd_ready_q <= 1'b0;
    end else begin
      rd_state_q <= rd_state_d;
      rd_ready_q <= (rd_state_d == RD_IDLE);
    end
  end

  // Captured at acceptance, before a same-cycle write lands
  always_ff @(posedge clk_int) begin
    if (rd_accept) begin
      rdata_q <= rf.rdata_a;
    end
  end

  assign rvalid_o = (rd_state_q == RD_RESP);
  assign rdata_o  = rdata_q;
  // Every index is mapped so reads never fail
  assign rresp_o  = AXI_RESP_OKAY;

endmodule

//--- design/rf_clock_gate.sv
/* Latch-based clock gating cell for the register file write clocks.
   Enable is captured while the clock is low so the output cannot glitch. */

`timescale 1ns/10ps

module rf_clock_gate (
  input  logic clk_i,
  input  logic en_i,
  output logic clk_o
);

  // Enable as seen at the last rising edge
  logic en_q;

  // Transparent during the low phase only
  always_latch begin
    if (!clk_i) begin
      en_q <= en_i;
    end
  end

  // Stable enable during the high phase keeps the pulse clean
  assign clk_o = clk_i & en_q;

endmodule

//--- design/rf_latch_regfile.sv
/* Latch based storage with 31 writable words and a hardwired zero word.
   Write data is sampled once on a gated clock, then each word latch opens
   through its own clock gate. Both read ports are combinational. */

`timescale 1ns/10ps

module rf_latch_regfile (
  input logic        clk_int,
  input logic        rst_n,
  rf_port_if.store   rf
);
  import rf_pkg::*;

  // Storage array, word 0 stays zero
  logic [RF_DATA_W-1:0] mem [RF_NUM_WORDS];

  // Write clock, only toggles in cycles that carry a write
  logic clk_wr;

  // Sampled write data feeding every word latch
  logic [RF_DATA_W-1:0] wdata_q;

  // Decoded write select and the resulting word clocks
  logic [RF_NUM_WORDS-1:1] waddr_onehot;
  logic [RF_NUM_WORDS-1:1] word_clk;

  ////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////

  // Plain array index, the zero word is part of the array
  assign rf.rdata_a = mem[rf.raddr_a];
  assign rf.rdata_b = mem[rf.raddr_b];

  ////////////////////////////////////////////////////////////
  // Write data sampling
  ////////////////////////////////////////////////////////////

  // Global gate opens for one cycle per accepted write
  rf_clock_gate cg_global_i (
    .clk_i (clk_int),
    .en_i  (rf.we),
    .clk_o (clk_wr)
  );

  // One flop bank for all words instead of one per latch
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wdata_q <= '0;
    end else begin
      wdata_q <= rf.wdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write address decode
  ////////////////////////////////////////////////////////////

  // One hot over words 1 to 31, word 0 has no select
  always_comb begin
    for (int i = 1; i < RF_NUM_WORDS; i++) begin
      waddr_onehot[i] = rf.we && (rf.waddr == RF_ADDR_W'(i));
    end
  end

  ////////////////////////////////////////////////////////////
  // Per word clock gates
  ////////////////////////////////////////////////////////////

  // Gates run from clk_wr so idle cycles do not toggle them
  for (genvar w = 1; w < RF_NUM_WORDS; w++) begin : gen_word_cg
    rf_clock_gate cg_word_i (
      .clk_i (clk_wr),
      .en_i  (waddr_onehot[w]),
      .clk_o (word_clk[w])
    );
  end

  ////////////////////////////////////////////////////////////
  // Word latches
  ////////////////////////////////////////////////////////////

  // Transparent while the word clock is high
  // wdata_q settles right after the rising edge and the latch follows it
  always_latch begin
    mem[0] <= '0;
    for (int k = 1; k < RF_NUM_WORDS; k++) begin
      if (word_clk[k]) begin
        mem[k] <= wdata_q;
      end
    end
  end

endmodule

//--- design/rf_pkg.sv
/* Shared constants for the latch register file and its AXI4-Lite slave.
   Imported by the RTL modules and the port interface. */

package rf_pkg;

  ////////////////////////////////////////////////////////////
  // Register file geometry
  ////////////////////////////////////////////////////////////

  // Width of a register index, full RV32I register set
  localparam int RF_ADDR_W = 5;

  // Register count including the hardwired zero register
  localparam int RF_NUM_WORDS = 2 ** RF_ADDR_W;

  // Register width, also used as the bus data width
  localparam int RF_DATA_W = 32;

  ////////////////////////////////////////////////////////////
  // AXI4-Lite bus
  ////////////////////////////////////////////////////////////

  // Byte address, index sits in bits 6 down to 2
  localparam int AXI_ADDR_W = 7;

  // Lowest address bit that belongs to the register index
  localparam int AXI_IDX_LSB = 2;

  // One strobe bit per data byte
  localparam int AXI_STRB_W = RF_DATA_W / 8;

  // Response field width and encodings
  localparam int AXI_RESP_W = 2;
  localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'b00;
  localparam logic [AXI_RESP_W-1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

//--- design/rf_port_if.sv
/* Register file port bundle between the bus slave and the latch storage.
   Two combinational read ports and one single-cycle write port. */

`timescale 1ns/10ps

interface rf_port_if;
  import rf_pkg::*;

  // Read port A, used by the bus slave
  logic [RF_ADDR_W-1:0] raddr_a;
  logic [RF_DATA_W-1:0] rdata_a;

  // Read port B, brought out as the probe
  logic [RF_ADDR_W-1:0] raddr_b;
  logic [RF_DATA_W-1:0] rdata_b;

  // Write port, we is a one-cycle pulse
  logic [RF_ADDR_W-1:0] waddr;
  logic [RF_DATA_W-1:0] wdata;
  logic                 we;

  // Bus side
  modport bus (output raddr_a, waddr, wdata, we, input rdata_a);

  // Storage side
  modport store (
    input  raddr_a, raddr_b, waddr, wdata, we,
    output rdata_a, rdata_b
  );

endinterface

//--- design/rf_top.sv
/* Register file subsystem top with an AXI4-Lite host port and a
   combinational probe read port for operand fetch. */

`timescale 1ns/10ps

module rf_top (
  input  logic                            clk_int,
  input  logic                            rst_n,
  input  logic                            awvalid_i,
  output logic                            awready_o,
  input  logic [rf_pkg::AXI_ADDR_W-1:0]   awaddr_i,
  input  logic                            wvalid_i,
  output logic                            wready_o,
  input  logic [rf_pkg::RF_DATA_W-1:0]    wdata_i,
  input  logic [rf_pkg::AXI_STRB_W-1:0]   wstrb_i,
  output logic                            bvalid_o,
  input  logic                            bready_i,
  output logic [rf_pkg::AXI_RESP_W-1:0]   bresp_o,
  input  logic                            arvalid_i,
  output logic                            arready_o,
  input  logic [rf_pkg::AXI_ADDR_W-1:0]   araddr_i,
  output logic                            rvalid_o,
  input  logic                            rready_i,
  output logic [rf_pkg::RF_DATA_W-1:0]    rdata_o,
  output logic [rf_pkg::AXI_RESP_W-1:0]   rresp_o,
  // Probe read port
  input  logic [rf_pkg::RF_ADDR_W-1:0]    probe_addr_i,
  output logic [rf_pkg::RF_DATA_W-1:0]    probe_data_o
);

  rf_port_if rf_port ();

  // Port B carries the probe straight through
  assign rf_port.raddr_b = probe_addr_i;
  assign probe_data_o    = rf_port.rdata_b;

  rf_axil_slave rf_axil_slave_i (
    .clk_int   (clk_int),
    .rst_n     (rst_n),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .awaddr_i  (awaddr_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .bresp_o   (bresp_o),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .araddr_i  (araddr_i),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rf        (rf_port.bus)
  );

  rf_latch_regfile rf_latch_regfile_i (
    .clk_int (clk_int),
    .rst_n   (rst_n),
    .rf      (rf_port.store)
  );

endmodule

//--- files.f
design/rf_pkg.sv
design/rf_port_if.sv
design/rf_clock_gate.sv
design/rf_latch_regfile.sv
design/rf_axil_slave.sv
design/rf_top.sv
tb/rf_props.sv
tb/rf_tb.sv

//--- run.sh
#!/bin/bash
# Builds the register file testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rf_tb -o rf_sim
./obj_dir/rf_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  echo "Register file run failed, see sim.log"
  exit 1
fi
echo "Register file run completed"

//--- tb/rf_props.sv
/* AXI4-Lite handshake checks for the register file top level.
   Attached to every rf_top instance through the bind below. */

`timescale 1ns/10ps

module rf_props (
  input logic                          clk_int,
  input logic                          rst_n,
  input logic                          awready_i,
  input logic                          bvalid_i,
  input logic                          bready_i,
  input logic [rf_pkg::AXI_RESP_W-1:0] bresp_i,
  input logic                          rvalid_i,
  input logic                          rready_i,
  input logic [rf_pkg::RF_DATA_W-1:0]  rdata_i
);

  // Write response stays up and unchanged until the master takes it
  a_b_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
    bvalid_i && !bready_i |=> bvalid_i && $stable(bresp_i))
    else $error("write response dropped or changed before bready");

  // Same rule on the read data channel
  a_r_hold: assert property (@(posedge clk_int) disable iff (!rst_n)
    rvalid_i && !rready_i |=> rvalid_i && $stable(rdata_i))
    else $error("read data dropped or changed before rready");

  // No new write while a response is pending
  a_aw_block: assert property (@(posedge clk_int) disable iff (!rst_n)
    bvalid_i |-> !awready_i)
    else $error("write address accepted while bvalid was high");

endmodule

bind rf_top rf_props rf_props_i (
  .clk_int   (clk_int),
  .rst_n     (rst_n),
  .awready_i (awready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .bresp_i   (bresp_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rdata_i   (rdata_o)
);

//--- tb/rf_tb.sv
/* Testbench for the register file subsystem. Fills every register over
   AXI4-Lite, then runs LFSR driven writes, reads and probes against a model. */

`timescale 1ns/10ps

module rf_tb;
  import rf_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int NUM_OPS       = 400;
  localparam int CYCLES_PER_OP = 10;
  localparam int RESP_WAIT     = 16;
  // Fill writes plus the two register 0 checks
  localparam int FILL_OPS      = RF_NUM_WORDS + 2;
  localparam longint WATCHDOG_NS =
    longint'(NUM_OPS + FILL_OPS) * CYCLES_PER_OP * CLK_PERIOD + 10 * CLK_PERIOD;

  logic clk_int;
  logic rst_n;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [AXI_ADDR_W-1:0] awaddr, araddr;
  logic [RF_DATA_W-1:0]  wdata, rdata, probe_data;
  logic [AXI_STRB_W-1:0] wstrb;
  logic [AXI_RESP_W-1:0] bresp, rresp;
  logic [RF_ADDR_W-1:0]  probe_addr;

  // Reference model, register 0 stays zero
  logic [RF_DATA_W-1:0] model [RF_NUM_WORDS];
  logic                 model_valid [RF_NUM_WORDS];

  logic [15:0] lfsr_state;
  int value_errs;
  int proto_errs;

  rf_top rf_top_i (
    .clk_int (clk_int), .rst_n (rst_n),
    .awvalid_i (awvalid), .awready_o (awready), .awaddr_i (awaddr),
    .wvalid_i (wvalid), .wready_o (wready), .wdata_i (wdata), .wstrb_i (wstrb),
    .bvalid_o (bvalid), .bready_i (bready), .bresp_o (bresp),
    .arvalid_i (arvalid), .arready_o (arready), .araddr_i (araddr),
    .rvalid_o (rvalid), .rready_i (rready), .rdata_o (rdata), .rresp_o (rresp),
    .probe_addr_i (probe_addr), .probe_data_o (probe_data)
  );

  initial begin
    clk_int = 1'b0;
    forever #(CLK_PERIOD / 2) clk_int = ~clk_int;
  end

  // Upper bound on the whole run
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish in %0d ns", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and error reporting
  ////////////////////////////////////////////////////////////

  // Taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per returned bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    value_errs++;
    $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, got, exp);
  endtask

  task automatic report_protocol(input string what);
    proto_errs++;
    $display("Protocol failure at %0t: %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and probe operations, all start on a falling edge
  ////////////////////////////////////////////////////////////

  // Falling edges until the response is valid, bounded
  task automatic wait_response(input bit is_read);
    int waited;
    waited = 0;
    do begin
      @(negedge clk_int);
      waited++;
    end while (!(is_read ? rvalid : bvalid) && waited < RESP_WAIT);
    assert (is_read ? rvalid : bvalid)
      else report_protocol("response valid never rose after the request");
  endtask

  // Valids stay up through the hold so a second acceptance would show
  task automatic axi_write(input logic [RF_ADDR_W-1:0] idx, input logic [31:0] data,
                           input logic [AXI_STRB_W-1:0] strb, input int hold);
    logic [AXI_RESP_W-1:0] exp_resp;
    exp_resp = (strb == '1) ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    awaddr  = {idx, 2'b00};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    wait_response(1'b0);
    assert (bresp == exp_resp) else report_mismatch("bresp", 32'(bresp), 32'(exp_resp));
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_int);
      assert (bvalid && bresp == exp_resp)
        else report_mismatch("held bresp", 32'(bresp), 32'(exp_resp));
      assert (!awready && !wready)
        else report_protocol("write accepted during back-pressure");
    end
    bready  = 1'b1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(negedge clk_int);
    bready = 1'b0;
    assert (!bvalid) else report_protocol("bvalid stayed high after bready");
    // Register 0 and refused writes leave the model alone
    if (exp_resp == AXI_RESP_OKAY && idx != 0) begin
      model[idx] = data;
    end
  endtask

  task automatic axi_read(input logic [RF_ADDR_W-1:0] idx, input int hold);
    araddr  = {idx, 2'b00};
    arvalid = 1'b1;
    wait_response(1'b1);
    assert (!model_valid[idx] || rdata == model[idx])
      else report_mismatch("rdata", rdata, model[idx]);
    assert (rresp == AXI_RESP_OKAY) else report_mismatch("rresp", 32'(rresp), 0);
    for (int i = 0; i < hold; i++) begin
      @(negedge clk_int);
      assert (rvalid && rdata == model[idx])
        else report_mismatch("held rdata", rdata, model[idx]);
      assert (!arready) else report_protocol("read accepted during back-pressure");
    end
    rready  = 1'b1;
    arvalid = 1'b0;
    @(negedge clk_int);
    rready = 1'b0;
    assert (!rvalid) else report_protocol("rvalid stayed high after rready");
  endtask

  task automatic probe_check(input logic [RF_ADDR_W-1:0] idx);
    probe_addr = idx;
    @(negedge clk_int);
    assert (!model_valid[idx] || probe_data == model[idx])
      else report_mismatch("probe_data", probe_data, model[idx]);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int op;
    int hold;
    logic [RF_ADDR_W-1:0]  idx;
    logic [RF_DATA_W-1:0]  data;
    logic [AXI_STRB_W-1:0] strb;
    lfsr_state = 16'd63598;
    value_errs = 0;
    proto_errs = 0;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    probe_addr = '0;
    for (int i = 0; i < RF_NUM_WORDS; i++) begin
      model[i]       = '0;
      model_valid[i] = (i == 0);
    end
    repeat (2) @(posedge clk_int);
    @(negedge clk_int);
    rst_n = 1'b1;
    @(negedge clk_int);
    assert (!bvalid && !rvalid) else report_protocol("response valid high after reset");

    // Fill so no latch is read before its first write
    for (int i = 0; i < RF_NUM_WORDS; i++) begin
      axi_write(RF_ADDR_W'(i), random_bits(RF_DATA_W), '1, 0);
      model_valid[i] = 1'b1;
    end
    // Register 0 was written with random data and must still read zero
    axi_read('0, 1);
    probe_check('0);

    for (int n = 0; n < NUM_OPS; n++) begin
      op   = random_bits(2);
      idx  = RF_ADDR_W'(random_bits(RF_ADDR_W));
      hold = random_bits(2);
      case (op)
        0, 1: begin
          data = random_bits(RF_DATA_W);
          strb = '1;
          // Partial strobe one time in four
          if (random_bits(2) == 0) begin
            strb = AXI_STRB_W'(random_bits(AXI_STRB_W));
            if (strb == '1) begin
              strb = 4'b0111;
            end
          end
          axi_write(idx, data, strb, hold);
        end
        2:       axi_read(idx, hold);
        default: probe_check(idx);
      endcase
    end

    $display("Error counts: %0d value mismatches, %0d protocol failures",
             value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
